// ==== hdl/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// pipeline address width
`define CACHE_ADDR_W 32

// data word and AXI data width
`define CACHE_XLEN 64

// byte offset inside a 32-byte line
`define CACHE_OFFSET_W 5

// 64 sets
`define CACHE_INDEX_W 6

// tag is what is left above index and offset
`define CACHE_TAG_W 21

// 64-bit words per line
`define CACHE_BEATS 4

`endif

// ==== hdl/cachePkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cachePkg;

  // pipeline address and data
  typedef logic [`CACHE_ADDR_W-1:0] cacheAddr_t;
  typedef logic [`CACHE_XLEN-1:0] cacheWord_t;

  // address fields
  typedef logic [`CACHE_TAG_W-1:0] cacheTag_t;
  typedef logic [`CACHE_INDEX_W-1:0] cacheIndex_t;
  typedef logic [$clog2(`CACHE_BEATS)-1:0] wordSel_t;

  // one bit picks one of the two ways
  typedef logic [0:0] way_t;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL
  } lookupState_t;

endpackage

`default_nettype wire

// ==== hdl/axiLitePkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package axiLitePkg;

  typedef logic [`CACHE_ADDR_W-1:0] axiAddr_t;
  typedef logic [`CACHE_XLEN-1:0] axiData_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axiResp_t;

  // read master sequencing for one line fill
  typedef enum logic [1:0] {
    RF_IDLE,
    RF_ADDR,
    RF_DATA
  } refillState_t;

endpackage

`default_nettype wire

// ==== hdl/cacheReqPort.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheReqPort (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       valid_i,
  input  wire cachePkg::cacheAddr_t addr_i,
  input  wire                       canAccept_i,
  input  wire                       hit_i,
  input  wire cachePkg::cacheWord_t hitWord_i,
  input  wire                       beatValid_i,
  input  wire cachePkg::wordSel_t   beatSel_i,
  input  wire cachePkg::cacheWord_t beatData_i,
  input  wire                       refillDone_i,
  output logic                      addr_ok_o,
  output logic                      reqFire_o,
  output cachePkg::cacheAddr_t      latchedAddr_o,
  output logic                      data_ok_o,
  output cachePkg::cacheWord_t      rd_data_o
);
  import cachePkg::*;

  wordSel_t reqSel;

  // ready straight from the lookup state, no register in between
  assign addr_ok_o = canAccept_i;
  assign reqFire_o = valid_i & addr_ok_o;

  // word wanted by the request in flight
  assign reqSel = latchedAddr_o[`CACHE_OFFSET_W-1 -: $bits(wordSel_t)];

  always_ff @(posedge clk) begin
    if (reqFire_o) begin
      latchedAddr_o <= addr_i;
    end
  end

  // one pulse per hit, and one at the end of each fill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_ok_o <= 1'b0;
    end else begin
      data_ok_o <= hit_i | refillDone_i;
    end
  end

  // hit word, or the matching beat picked off the fill as it passes
  always_ff @(posedge clk) begin
    if (hit_i) begin
      rd_data_o <= hitWord_i;
    end else if (beatValid_i && (beatSel_i == reqSel)) begin
      rd_data_o <= beatData_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cacheLookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheLookup (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       reqFire_i,
  input  wire cachePkg::cacheAddr_t reqAddr_i,
  input  wire cachePkg::cacheAddr_t latchedAddr_i,
  input  wire                       refillDone_i,
  input  wire                       refillOk_i,
  output logic                      canAccept_o,
  output logic                      hit_o,
  output cachePkg::way_t            hitWay_o,
  output logic                      missStart_o,
  output cachePkg::way_t            victimWay_o
);
  import cachePkg::*;

  localparam int NumSets = 1 << `CACHE_INDEX_W;

  lookupState_t state;
  lookupState_t stateNext;

  cacheTag_t tagArray [0:1][0:NumSets-1];
  logic [1:0][NumSets-1:0] validBits;
  // lru bit names the way to replace next
  logic [NumSets-1:0] lruBits;

  cacheTag_t tagQ [0:1];
  logic [1:0] validQ;
  logic [1:0] wayHit;
  logic anyHit;

  cacheIndex_t reqIndex;
  cacheIndex_t latIndex;
  cacheTag_t latTag;
  way_t victimPick;
  way_t victimQ;

  assign reqIndex = reqAddr_i[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
  assign latIndex = latchedAddr_i[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
  assign latTag = latchedAddr_i[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

  // tags are read on acceptance and written at the end of a fill
  always_ff @(posedge clk) begin
    if (reqFire_i) begin
      tagQ[0] <= tagArray[0][reqIndex];
      tagQ[1] <= tagArray[1][reqIndex];
    end
    if (refillDone_i) begin
      tagArray[victimQ][latIndex] <= latTag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= 2'b00;
    end else if (reqFire_i) begin
      validQ <= {validBits[1][reqIndex], validBits[0][reqIndex]};
    end
  end

  // compare in the LOOKUP cycle against the latched tag
  assign wayHit[0] = validQ[0] && (tagQ[0] == latTag);
  assign wayHit[1] = validQ[1] && (tagQ[1] == latTag);
  assign anyHit = |wayHit;

  assign hit_o = (state == LOOKUP) && anyHit;
  assign hitWay_o = wayHit[1];
  assign missStart_o = (state == LOOKUP) && !anyHit;
  assign canAccept_o = (state == IDLE) || hit_o;

  // empty way first, LRU way otherwise
  always_comb begin
    if (!validQ[0]) begin
      victimPick = 1'b0;
    end else if (!validQ[1]) begin
      victimPick = 1'b1;
    end else begin
      victimPick = lruBits[latIndex];
    end
  end

  always_ff @(posedge clk) begin
    if (missStart_o) begin
      victimQ <= victimPick;
    end
  end

  assign victimWay_o = victimQ;

  // a failed fill leaves the victim invalid, its old data is gone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      lruBits <= '0;
    end else if (refillDone_i) begin
      validBits[victimQ][latIndex] <= refillOk_i;
      if (refillOk_i) begin
        lruBits[latIndex] <= ~victimQ;
      end
    end else if (hit_o) begin
      lruBits[latIndex] <= ~hitWay_o;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (reqFire_i) begin
          stateNext = LOOKUP;
        end
      end
      LOOKUP: begin
        if (!anyHit) begin
          stateNext = REFILL;
        end else if (!reqFire_i) begin
          stateNext = IDLE;
        end
      end
      REFILL: begin
        if (refillDone_i) begin
          stateNext = IDLE;
        end
      end
      default: stateNext = IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/cacheDataStore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheDataStore (
  input  wire                       clk,
  input  wire                       reqFire_i,
  input  wire cachePkg::cacheAddr_t reqAddr_i,
  input  wire cachePkg::cacheAddr_t latchedAddr_i,
  input  wire cachePkg::way_t       hitWay_i,
  input  wire cachePkg::way_t       victimWay_i,
  input  wire                       beatValid_i,
  input  wire cachePkg::wordSel_t   beatSel_i,
  input  wire cachePkg::cacheWord_t beatData_i,
  output cachePkg::cacheWord_t      hitWord_o
);
  import cachePkg::*;

  localparam int NumSets = 1 << `CACHE_INDEX_W;

  cacheWord_t lineMem [0:1][0:NumSets-1][0:`CACHE_BEATS-1];
  // both ways of the addressed set, one cycle after acceptance
  cacheWord_t lineQ [0:1][0:`CACHE_BEATS-1];

  cacheIndex_t reqIndex;
  cacheIndex_t latIndex;
  wordSel_t latSel;

  assign reqIndex = reqAddr_i[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
  assign latIndex = latchedAddr_i[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
  assign latSel = latchedAddr_i[`CACHE_OFFSET_W-1 -: $bits(wordSel_t)];

  // fill beats go into the chosen victim
  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      lineMem[victimWay_i][latIndex][beatSel_i] <= beatData_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reqFire_i) begin
      for (int w = 0; w < 2; w++) begin
        for (int b = 0; b < `CACHE_BEATS; b++) begin
          lineQ[w][b] <= lineMem[w][reqIndex][b];
        end
      end
    end
  end

  assign hitWord_o = lineQ[hitWay_i][latSel];

endmodule

`default_nettype wire

// ==== hdl/cacheRefill.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cacheRefill (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         missStart_i,
  input  wire cachePkg::cacheAddr_t   latchedAddr_i,
  input  wire                         m_axi_arready_i,
  input  wire                         m_axi_rvalid_i,
  input  wire axiLitePkg::axiData_t   m_axi_rdata_i,
  input  wire axiLitePkg::axiResp_t   m_axi_rresp_i,
  output axiLitePkg::axiAddr_t        m_axi_araddr_o,
  output logic                        m_axi_arvalid_o,
  output logic                        m_axi_rready_o,
  output logic                        beatValid_o,
  output cachePkg::wordSel_t          beatSel_o,
  output cachePkg::cacheWord_t        beatData_o,
  output logic                        refillDone_o,
  output logic                        refillOk_o
);
  import cachePkg::*;
  import axiLitePkg::*;

  localparam int ByteW = `CACHE_OFFSET_W - $bits(wordSel_t);

  refillState_t state;
  refillState_t stateNext;
  wordSel_t beatCnt;
  logic errSeen;
  logic beatFire;
  logic lastBeat;

  // address comes straight from state, so it holds while arvalid waits
  assign m_axi_arvalid_o = (state == RF_ADDR);
  assign m_axi_rready_o = (state == RF_DATA);
  assign m_axi_araddr_o = {latchedAddr_i[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], beatCnt,
                           {ByteW{1'b0}}};

  assign beatFire = m_axi_rvalid_i & m_axi_rready_o;
  assign lastBeat = (beatCnt == wordSel_t'(`CACHE_BEATS - 1));

  assign beatValid_o = beatFire;
  assign beatSel_o = beatCnt;
  assign beatData_o = m_axi_rdata_i;
  assign refillDone_o = beatFire && lastBeat;
  // the last response counts too
  assign refillOk_o = !errSeen && (m_axi_rresp_i == OKAY);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RF_IDLE;
      beatCnt <= '0;
      errSeen <= 1'b0;
    end else begin
      state <= stateNext;
      if (missStart_i) begin
        beatCnt <= '0;
        errSeen <= 1'b0;
      end else if (beatFire) begin
        beatCnt <= beatCnt + 1'b1;
        if (m_axi_rresp_i != OKAY) begin
          errSeen <= 1'b1;
        end
      end
    end
  end

  // one AR and one R per word, words 0 to 3 in order
  always_comb begin
    stateNext = state;
    case (state)
      RF_IDLE: begin
        if (missStart_i) begin
          stateNext = RF_ADDR;
        end
      end
      RF_ADDR: begin
        if (m_axi_arready_i) begin
          stateNext = RF_DATA;
        end
      end
      RF_DATA: begin
        if (m_axi_rvalid_i) begin
          stateNext = lastBeat ? RF_IDLE : RF_ADDR;
        end
      end
      default: stateNext = RF_IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/setAssocCache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module setAssocCache (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       valid_i,
  input  wire cachePkg::cacheAddr_t addr_i,
  output logic                      addr_ok_o,
  output logic                      data_ok_o,
  output cachePkg::cacheWord_t      rd_data_o,
  output axiLitePkg::axiAddr_t      m_axi_araddr_o,
  output logic                      m_axi_arvalid_o,
  input  wire                       m_axi_arready_i,
  input  wire                       m_axi_rvalid_i,
  input  wire axiLitePkg::axiData_t m_axi_rdata_i,
  input  wire axiLitePkg::axiResp_t m_axi_rresp_i,
  output logic                      m_axi_rready_o
);
  import cachePkg::*;

  logic reqFire;
  cacheAddr_t latchedAddr;
  logic canAccept;
  logic hit;
  way_t hitWay;
  logic missStart;
  way_t victimWay;
  cacheWord_t hitWord;

  // fill beat stream
  logic beatValid;
  wordSel_t beatSel;
  cacheWord_t beatData;
  logic refillDone;
  logic refillOk;

  cacheReqPort i_reqPort (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .addr_i        (addr_i),
    .canAccept_i   (canAccept),
    .hit_i         (hit),
    .hitWord_i     (hitWord),
    .beatValid_i   (beatValid),
    .beatSel_i     (beatSel),
    .beatData_i    (beatData),
    .refillDone_i  (refillDone),
    .addr_ok_o     (addr_ok_o),
    .reqFire_o     (reqFire),
    .latchedAddr_o (latchedAddr),
    .data_ok_o     (data_ok_o),
    .rd_data_o     (rd_data_o)
  );

  cacheLookup i_lookup (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqFire_i     (reqFire),
    .reqAddr_i     (addr_i),
    .latchedAddr_i (latchedAddr),
    .refillDone_i  (refillDone),
    .refillOk_i    (refillOk),
    .canAccept_o   (canAccept),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .missStart_o   (missStart),
    .victimWay_o   (victimWay)
  );

  cacheDataStore i_dataStore (
    .clk           (clk),
    .reqFire_i     (reqFire),
    .reqAddr_i     (addr_i),
    .latchedAddr_i (latchedAddr),
    .hitWay_i      (hitWay),
    .victimWay_i   (victimWay),
    .beatValid_i   (beatValid),
    .beatSel_i     (beatSel),
    .beatData_i    (beatData),
    .hitWord_o     (hitWord)
  );

  cacheRefill i_refill (
    .clk             (clk),
    .rst_n           (rst_n),
    .missStart_i     (missStart),
    .latchedAddr_i   (latchedAddr),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rresp_i   (m_axi_rresp_i),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_rready_o  (m_axi_rready_o),
    .beatValid_o     (beatValid),
    .beatSel_o       (beatSel),
    .beatData_o      (beatData),
    .refillDone_o    (refillDone),
    .refillOk_o      (refillOk)
  );

endmodule

`default_nettype wire

// ==== tests/axiLiteMemModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module axiLiteMemModel (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       stallEn_i,
  input  wire axiLitePkg::axiAddr_t errLine_i,
  input  wire axiLitePkg::axiAddr_t araddr_i,
  input  wire                       arvalid_i,
  output logic                      arready_o,
  output logic                      rvalid_o,
  output axiLitePkg::axiData_t      rdata_o,
  output axiLitePkg::axiResp_t      rresp_o,
  input  wire                       rready_i,
  output int                        arCount_o
);
  import axiLitePkg::*;

  // every accepted AR address, in order
  axiAddr_t arLog [0:511];
  axiAddr_t pendAddr;
  logic rPend;
  logic [2:0] arDelay;
  logic [2:0] rDelay;
  logic [2:0] stall;
  logic [31:0] lfsr;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // 0 to 7 wait cycles from three LFSR bits
  task automatic pickStall(output logic [2:0] d);
    int i;
    d = 3'd0;
    if (stallEn_i) begin
      for (i = 0; i < 3; i++) begin
        lfsr = lfsrStep(lfsr);
        d = {d[1:0], lfsr[0]};
      end
    end
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready_o <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o <= '0;
      rresp_o <= OKAY;
      rPend <= 1'b0;
      arDelay <= 3'd0;
      rDelay <= 3'd0;
      arCount_o <= 0;
      pendAddr <= '0;
      lfsr = 32'h6309;
    end else begin
      if (arvalid_i && arready_o) begin
        pickStall(stall);
        arready_o <= 1'b0;
        arLog[arCount_o[8:0]] <= araddr_i;
        arCount_o <= arCount_o + 1;
        pendAddr <= araddr_i;
        rPend <= 1'b1;
        rDelay <= stall;
      end else if (arvalid_i && !rPend && !rvalid_o) begin
        if (arDelay == 3'd0) begin
          arready_o <= 1'b1;
        end else begin
          arDelay <= arDelay - 3'd1;
        end
      end
      if (rvalid_o && rready_i) begin
        pickStall(stall);
        rvalid_o <= 1'b0;
        arDelay <= stall;
      end else if (rPend) begin
        if (rDelay == 3'd0) begin
          rvalid_o <= 1'b1;
          rPend <= 1'b0;
          // address in the upper half, its inverse below
          rdata_o <= {pendAddr, ~pendAddr};
          // only the one chosen word of the error line answers SLVERR
          rresp_o <= (pendAddr[31:3] == errLine_i[31:3]) ? SLVERR : OKAY;
        end else begin
          rDelay <= rDelay - 3'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_setAssocCache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_setAssocCache;
  import cachePkg::*;
  import axiLitePkg::*;

  localparam int ResetCycles = 16;
  localparam int NumStream = 8;
  localparam int NumSweep = 40;
  localparam int NumRequests = 2 + 1 + NumStream + 6 + 6 + 2 + NumSweep;
  localparam int TimeoutCycles = NumRequests * 80 + ResetCycles;
  // tag 2 set 2, and tag 4 set 3
  localparam cacheAddr_t LineOne = 32'h0000_1040;
  localparam cacheAddr_t LineTwo = 32'h0000_2060;
  // word 1 of tag 0x30 set 9
  localparam axiAddr_t ErrLine = 32'h0001_8128;

  logic clk;
  logic rst_n;
  logic valid;
  cacheAddr_t addr;
  logic addrOk;
  logic dataOk;
  cacheWord_t rdData;
  axiAddr_t araddr;
  logic arvalid;
  logic arready;
  logic rvalid;
  axiData_t rdata;
  axiResp_t rresp;
  logic rready;
  logic stallEn;
  int arCount;

  int cycles;
  int lastRespCycle;
  int numChecks;
  int mismatches;
  int otherErrors;
  logic [31:0] lfsr;
  logic arWaitPrev;
  cacheWord_t expQ [$];

  // reference copy of tags, valid bits and LRU
  logic refValid [0:1][0:63];
  cacheTag_t refTag [0:1][0:63];
  way_t refLru [0:63];

  setAssocCache i_setAssocCache (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_i         (valid),
    .addr_i          (addr),
    .addr_ok_o       (addrOk),
    .data_ok_o       (dataOk),
    .rd_data_o       (rdData),
    .m_axi_araddr_o  (araddr),
    .m_axi_arvalid_o (arvalid),
    .m_axi_arready_i (arready),
    .m_axi_rvalid_i  (rvalid),
    .m_axi_rdata_i   (rdata),
    .m_axi_rresp_i   (rresp),
    .m_axi_rready_o  (rready)
  );

  axiLiteMemModel i_memModel (
    .clk       (clk),
    .rst_n     (rst_n),
    .stallEn_i (stallEn),
    .errLine_i (ErrLine),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .rready_i  (rready),
    .arCount_o (arCount)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TimeoutCycles) begin
      $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // responses come back in request order
  always @(negedge clk) begin
    if (rst_n && dataOk) begin
      if (expQ.size() == 0) begin
        otherErrors++;
        $display("data_ok_o pulsed with no request outstanding");
      end else begin
        checkWord("rd_data_o", expQ.pop_front(), rdData);
      end
      lastRespCycle = cycles;
    end
  end

  // arvalid holds until arready, rready only while a beat is awaited
  always @(negedge clk) begin
    if (rst_n) begin
      if (arWaitPrev) begin
        checkBit("m_axi_arvalid_o", 1'b1, arvalid);
      end
      if (rready && !(i_memModel.rPend || rvalid)) begin
        otherErrors++;
        $display("m_axi_rready_o high with no read outstanding");
      end
    end
    arWaitPrev = rst_n && arvalid && !arready;
  end

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  // memory word holds the address on top and its inverse below
  function automatic cacheWord_t expectedWord(input cacheAddr_t a);
    cacheAddr_t w;
    w = {a[`CACHE_ADDR_W-1:3], 3'b000};
    return {w, ~w};
  endfunction

  function automatic cacheAddr_t makeAddr(input cacheTag_t t, input cacheIndex_t s,
                                          input wordSel_t w);
    return {t, s, w, 3'b000};
  endfunction

  // returns 1 on a hit and applies the access to the reference state
  function automatic logic predictAccess(input cacheAddr_t a);
    cacheIndex_t idx;
    cacheTag_t tag;
    way_t v;
    int w;
    idx = a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    tag = a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    for (w = 0; w < 2; w++) begin
      if (refValid[w][idx] && refTag[w][idx] == tag) begin
        refLru[idx] = (w == 0) ? 1'b1 : 1'b0;
        return 1'b1;
      end
    end
    if (!refValid[0][idx]) begin
      v = 1'b0;
    end else if (!refValid[1][idx]) begin
      v = 1'b1;
    end else begin
      v = refLru[idx];
    end
    // an erroring fill leaves the way empty and LRU untouched
    if (a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W] == ErrLine[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]) begin
      refValid[v][idx] = 1'b0;
    end else begin
      refValid[v][idx] = 1'b1;
      refTag[v][idx] = tag;
      refLru[idx] = ~v;
    end
    return 1'b0;
  endfunction

  task automatic checkWord(input string name, input cacheWord_t exp, input cacheWord_t act);
    numChecks++;
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic checkAddr(input string name, input axiAddr_t exp, input axiAddr_t act);
    numChecks++;
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic checkHit(input string name, input int expCount, input int actCount);
    numChecks++;
    if (expCount != actCount) begin
      mismatches++;
      $display("Mismatch %s: expected %h, got %h", name, expCount, actCount);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    numChecks++;
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch %s: expected %h, got %h", name, exp, act);
    end
  endtask

  // handshake outputs while the cache sits idle in reset
  task automatic checkResetOutputs();
    checkBit("data_ok_o", 1'b0, dataOk);
    checkBit("m_axi_arvalid_o", 1'b0, arvalid);
    checkBit("m_axi_rready_o", 1'b0, rready);
    checkBit("addr_ok_o", 1'b1, addrOk);
  endtask

  // one request, waits for its response; starts and ends on a falling edge
  task automatic readWord(input cacheAddr_t a);
    int arBefore;
    int start;
    int k;
    logic expHit;
    axiAddr_t lineBase;
    while (!addrOk) begin
      @(negedge clk);
    end
    arBefore = arCount;
    expHit = predictAccess(a);
    lineBase = {a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    valid = 1'b1;
    addr = a;
    expQ.push_back(expectedWord(a));
    start = cycles;
    @(negedge clk);
    valid = 1'b0;
    while (!dataOk) begin
      if (!expHit && addrOk) begin
        otherErrors++;
        $display("addr_ok_o high while the miss at %h is pending", a);
      end
      @(negedge clk);
    end
    if (expHit && (cycles - start != 2)) begin
      otherErrors++;
      $display("hit at %h answered %0d cycles after acceptance, not 2", a, cycles - start);
    end
    checkHit("AR handshakes", expHit ? 0 : `CACHE_BEATS, arCount - arBefore);
    if (!expHit) begin
      for (k = 0; k < `CACHE_BEATS; k++) begin
        checkAddr("m_axi_araddr_o", lineBase + axiAddr_t'(k * 8),
                  i_memModel.arLog[arBefore + k]);
      end
    end
  endtask

  // a new hit every cycle, alternating between the two resident lines
  task automatic streamHits(input int count);
    int arBefore;
    int start;
    int i;
    cacheAddr_t a;
    arBefore = arCount;
    start = cycles;
    for (i = 0; i < count; i++) begin
      a = ((i % 2) == 0 ? LineOne : LineTwo) + cacheAddr_t'(8 * ((i / 2) % 4));
      void'(predictAccess(a));
      valid = 1'b1;
      addr = a;
      expQ.push_back(expectedWord(a));
      if (!addrOk) begin
        otherErrors++;
        $display("addr_ok_o low during back-to-back hits at request %0d", i);
      end
      @(negedge clk);
    end
    valid = 1'b0;
    while (expQ.size() != 0) begin
      @(negedge clk);
    end
    checkHit("AR handshakes", 0, arCount - arBefore);
    if (lastRespCycle - start != count + 1) begin
      otherErrors++;
      $display("back-to-back hit responses were not on consecutive cycles");
    end
  endtask

  task automatic coldMissThenHit();
    readWord(LineOne + 32'h10);
    readWord(LineOne + 32'h08);
  endtask

  task automatic backToBackHits();
    readWord(LineTwo + 32'h18);
    streamHits(NumStream);
  endtask

  // A, B, C share set 5
  task automatic replacement();
    readWord(makeAddr(21'h10, 6'd5, 2'd0));
    readWord(makeAddr(21'h11, 6'd5, 2'd1));
    readWord(makeAddr(21'h10, 6'd5, 2'd2));
    readWord(makeAddr(21'h12, 6'd5, 2'd3));
    readWord(makeAddr(21'h10, 6'd5, 2'd1));
    readWord(makeAddr(21'h11, 6'd5, 2'd0));
  endtask

  task automatic backPressure();
    stallEn = 1'b1;
    readWord(makeAddr(21'h20, 6'd7, 2'd0));
    readWord(makeAddr(21'h21, 6'd7, 2'd3));
    readWord(makeAddr(21'h20, 6'd7, 2'd1));
    readWord(makeAddr(21'h22, 6'd8, 2'd2));
    readWord(makeAddr(21'h22, 6'd8, 2'd0));
    readWord(makeAddr(21'h23, 6'd7, 2'd2));
  endtask

  task automatic busError();
    readWord(ErrLine + 32'h08);
    readWord(ErrLine + 32'h08);
  endtask

  // 4 tags over sets 12 to 15
  task automatic randomSweep(input int count);
    logic [31:0] bits;
    int i;
    for (i = 0; i < count; i++) begin
      takeBits(6, bits);
      readWord(makeAddr(21'h40 + cacheTag_t'(bits[5:4]), 6'd12 + cacheIndex_t'(bits[3:2]),
                        bits[1:0]));
    end
  endtask

  initial begin
    int s;
    clk = 1'b0;
    rst_n = 1'b0;
    valid = 1'b0;
    addr = '0;
    stallEn = 1'b0;
    cycles = 0;
    lastRespCycle = 0;
    numChecks = 0;
    mismatches = 0;
    otherErrors = 0;
    arWaitPrev = 1'b0;
    lfsr = 32'h6309;
    for (s = 0; s < 64; s++) begin
      refValid[0][s] = 1'b0;
      refValid[1][s] = 1'b0;
      refTag[0][s] = '0;
      refTag[1][s] = '0;
      refLru[s] = 1'b0;
    end
    repeat (ResetCycles) @(negedge clk);
    checkResetOutputs();
    rst_n = 1'b1;
    @(negedge clk);
    coldMissThenHit();
    backToBackHits();
    replacement();
    backPressure();
    busError();
    randomSweep(NumSweep);
    repeat (2) @(negedge clk);
    $display("%0d checks, %0d mismatches, %0d other errors", numChecks, mismatches,
             otherErrors);
    if (mismatches == 0 && otherErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== setAssocCache.f ====
+incdir+hdl
hdl/cachePkg.sv
hdl/axiLitePkg.sv
hdl/cacheReqPort.sv
hdl/cacheLookup.sv
hdl/cacheDataStore.sv
hdl/cacheRefill.sv
hdl/setAssocCache.sv
tests/axiLiteMemModel.sv
tests/tb_setAssocCache.sv

// ==== Makefile ====
# Verilator flow for the set-associative cache

VERILATOR ?= verilator
TOP       ?= tb_setAssocCache
RTL_TOP   ?= setAssocCache
FILELIST  ?= setAssocCache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
